// File: hw/layer_cfg.svh
`ifndef LAYER_CFG_SVH
`define LAYER_CFG_SVH

// Layer shape.
`define LAYER_INPUTS 15
`define LAYER_NEURONS 4

// Q4.12 data, wide accumulator.
`define DATA_WIDTH 16
`define FRAC_BITS 12
`define ACC_WIDTH 40

// Queue depth matches the producer's starting credits.
`define IN_DEPTH 2
`define OUT_CREDITS 2

`endif

// File: hw/layerPkg.sv
`include "layer_cfg.svh"

package layerPkg;

	// Index bits per neuron, weights plus one bias slot.
	localparam int IdxWidth = 4;

	typedef logic signed [`DATA_WIDTH-1:0] actT;
	typedef actT [`LAYER_INPUTS-1:0] actVecT;
	typedef actT [`LAYER_NEURONS-1:0] resVecT;
	typedef logic signed [`ACC_WIDTH-1:0] accT;
	typedef logic [1:0] neuronIdT;

	typedef struct packed {
		neuronIdT neuron;
		logic [IdxWidth-1:0] idx;
	} addrT;

endpackage

// File: hw/weightRom.sv
`timescale 1ns/10ps
`include "layer_cfg.svh"

module weightRom import layerPkg::*;
(
	input  logic clk,
	input  logic rdEn,
	input  addrT rdAddr,
	output actT  rdData
);

	localparam int Slots = 2 ** IdxWidth;

	actT romWord [0:`LAYER_NEURONS*Slots-1];

	// Weights in 1/16 steps, bias last.
	for (genvar n = 0; n < `LAYER_NEURONS; n++)
	begin : genNeuron
		for (genvar i = 0; i < Slots; i++)
		begin : genSlot
			localparam int Raw = (i == `LAYER_INPUTS) ? (n - 1) * 1024 :
				(i < `LAYER_INPUTS) ? (((7 * n + 3 * i + 1) % 11) - 5) * 256 : 0;

			assign romWord[n * Slots + i] = actT'(Raw);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rdEn)
		begin
			rdData <= romWord[rdAddr];
		end
	end

endmodule

// File: hw/weightArbiter.sv
`timescale 1ns/10ps
`include "layer_cfg.svh"

module weightArbiter import layerPkg::*;
(
	input  logic                      clk,
	input  logic                      rstN,
	input  logic [`LAYER_NEURONS-1:0] req,
	input  addrT [`LAYER_NEURONS-1:0] reqAddr,
	output logic [`LAYER_NEURONS-1:0] gnt,
	output logic [`LAYER_NEURONS-1:0] rdVld,
	output actT                       rdData
);

	neuronIdT ptr;
	neuronIdT cand;
	neuronIdT gntIdx;
	logic     anyGnt;
	neuronIdT rdIdx;
	logic     rdPend;

	// First requester at or after the pointer.
	always_comb
	begin
		gnt = '0;
		cand = ptr;
		gntIdx = ptr;
		anyGnt = 1'b0;
		for (int k = 0; k < `LAYER_NEURONS; k++)
		begin
			cand = ptr + neuronIdT'(k);
			if (!anyGnt && req[cand])
			begin
				gnt[cand] = 1'b1;
				gntIdx = cand;
				anyGnt = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			ptr <= '0;
			rdPend <= 1'b0;
			rdIdx <= '0;
		end
		else
		begin
			rdPend <= anyGnt;
			if (anyGnt)
			begin
				ptr <= gntIdx + 1'b1;
				rdIdx <= gntIdx;
			end
		end
	end

	// Data lands one cycle after the grant.
	assign rdVld = rdPend ? (`LAYER_NEURONS'(1) << rdIdx) : '0;

	weightRom rom (
		.clk    (clk),
		.rdEn   (anyGnt),
		.rdAddr (reqAddr[gntIdx]),
		.rdData (rdData)
	);

endmodule

// File: hw/neuronMac.sv
`timescale 1ns/10ps
`include "layer_cfg.svh"

module neuronMac import layerPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     start,
	input  actVecT   inVec,
	input  neuronIdT myId,
	output logic     req,
	output addrT     addr,
	input  logic     gnt,
	input  logic     rdVld,
	input  actT      rdData,
	output logic     done,
	output actT      result
);

	localparam int BiasIdx = `LAYER_INPUTS;
	localparam accT MaxAct = (accT'(1) <<< (`DATA_WIDTH - 1)) - 1;
	localparam accT MinAct = -(accT'(1) <<< (`DATA_WIDTH - 1));

	logic                busy;
	logic [IdxWidth:0]   reqCnt;
	logic [IdxWidth-1:0] rcvCnt;
	logic                lastRcv;
	actVecT              vecQ;
	accT                 acc;
	accT                 term;
	accT                 total;
	accT                 scaled;
	actT                 clipped;

	// ##############################
	// Read requests
	// ##############################

	assign req = busy && (reqCnt <= BiasIdx);
	assign addr = '{neuron: myId, idx: reqCnt[IdxWidth-1:0]};
	assign lastRcv = rdVld && (rcvCnt == IdxWidth'(BiasIdx));

	// ##############################
	// Arithmetic
	// ##############################

	always_comb
	begin
		// Bias moves up to the product scale.
		if (rcvCnt == IdxWidth'(BiasIdx))
			term = accT'(rdData) <<< `FRAC_BITS;
		else
			term = accT'(rdData) * accT'($signed(vecQ[rcvCnt]));
		total = acc + term;
		scaled = total >>> `FRAC_BITS;
		if (scaled > MaxAct)
			clipped = actT'(MaxAct);
		else if (scaled < MinAct)
			clipped = actT'(MinAct);
		else
			clipped = actT'(scaled);
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			reqCnt <= '0;
			rcvCnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				reqCnt <= '0;
				rcvCnt <= '0;
			end
			else if (busy)
			begin
				if (gnt)
				begin
					reqCnt <= reqCnt + 1'b1;
				end
				if (rdVld)
				begin
					rcvCnt <= rcvCnt + 1'b1;
				end
				if (lastRcv)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			vecQ <= inVec;
			acc <= '0;
		end
		else if (rdVld)
		begin
			acc <= total;
			// Rectifier.
			if (lastRcv)
			begin
				result <= clipped[`DATA_WIDTH-1] ? '0 : clipped;
			end
		end
	end

endmodule

// File: hw/inputQueue.sv
`timescale 1ns/10ps
`include "layer_cfg.svh"

module inputQueue import layerPkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  logic   inVld,
	input  actVecT inVec,
	output logic   qVld,
	output actVecT qVec,
	input  logic   popReq,
	output logic   inCredit
);

	localparam int PtrW = (`IN_DEPTH > 1) ? $clog2(`IN_DEPTH) : 1;
	localparam int CntW = $clog2(`IN_DEPTH + 1);

	actVecT          mem [`IN_DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;
	logic            push;
	logic            pop;

	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
		return (p == PtrW'(`IN_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign qVld = (count != '0);
	assign qVec = mem[rdPtr];
	assign push = inVld && (count != CntW'(`IN_DEPTH));
	assign pop = popReq && qVld;

	// One credit back per vector consumed.
	assign inCredit = pop;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
			begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop)
			begin
				rdPtr <= nextPtr(rdPtr);
			end
			count <= count + CntW'(push) - CntW'(pop);
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem[wrPtr] <= inVec;
		end
	end

endmodule

// File: hw/layerControl.sv
`timescale 1ns/10ps
`include "layer_cfg.svh"

module layerControl import layerPkg::*;
(
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      qVld,
	input  actVecT                    qVec,
	output logic                      popReq,
	output logic                      start,
	output actVecT                    startVec,
	input  logic [`LAYER_NEURONS-1:0] done,
	input  actT [`LAYER_NEURONS-1:0]  result,
	output logic                      outVld,
	output resVecT                    outVec,
	input  logic                      outCreditRet
);

	typedef enum logic [1:0] {Idle, Running, Holding} stateT;

	localparam int CredW = $clog2(`OUT_CREDITS + 1);

	stateT                     state;
	logic [`LAYER_NEURONS-1:0] doneSeen;
	logic [CredW-1:0]          credits;
	logic                      allDone;

	assign popReq = (state == Idle) && qVld;
	assign outVld = (state == Holding) && (credits != '0);
	assign allDone = &(doneSeen | done);

	// ##############################
	// FSM and output credits
	// ##############################

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= Idle;
			start <= 1'b0;
			doneSeen <= '0;
			credits <= CredW'(`OUT_CREDITS);
		end
		else
		begin
			start <= popReq;
			credits <= credits - CredW'(outVld) + CredW'(outCreditRet);
			case (state)
				Idle:
				begin
					if (popReq)
					begin
						state <= Running;
						doneSeen <= '0;
					end
				end
				Running:
				begin
					doneSeen <= doneSeen | done;
					if (allDone)
					begin
						state <= Holding;
					end
				end
				Holding:
				begin
					if (outVld)
					begin
						state <= Idle;
					end
				end
				default:
				begin
					state <= Idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (popReq)
		begin
			startVec <= qVec;
		end
		for (int k = 0; k < `LAYER_NEURONS; k++)
		begin
			if (done[k])
			begin
				outVec[k] <= result[k];
			end
		end
	end

endmodule

// File: hw/denseLayer.sv
`timescale 1ns/10ps
`include "layer_cfg.svh"

module denseLayer import layerPkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  logic   inVld,
	input  actVecT inVec,
	output logic   inCredit,
	output logic   outVld,
	output resVecT outVec,
	input  logic   outCreditRet
);

	logic                      qVld;
	actVecT                    qVec;
	logic                      popReq;
	logic                      start;
	actVecT                    startVec;
	logic [`LAYER_NEURONS-1:0] done;
	actT [`LAYER_NEURONS-1:0]  result;
	logic [`LAYER_NEURONS-1:0] req;
	addrT [`LAYER_NEURONS-1:0] reqAddr;
	logic [`LAYER_NEURONS-1:0] gnt;
	logic [`LAYER_NEURONS-1:0] rdVld;
	actT                       rdData;

	inputQueue queue (
		.clk      (clk),
		.rstN     (rstN),
		.inVld    (inVld),
		.inVec    (inVec),
		.qVld     (qVld),
		.qVec     (qVec),
		.popReq   (popReq),
		.inCredit (inCredit)
	);

	layerControl control (
		.clk          (clk),
		.rstN         (rstN),
		.qVld         (qVld),
		.qVec         (qVec),
		.popReq       (popReq),
		.start        (start),
		.startVec     (startVec),
		.done         (done),
		.result       (result),
		.outVld       (outVld),
		.outVec       (outVec),
		.outCreditRet (outCreditRet)
	);

	// Neurons share the ROM port.
	for (genvar g = 0; g < `LAYER_NEURONS; g++)
	begin : genNeuron
		neuronMac neuron (
			.clk    (clk),
			.rstN   (rstN),
			.start  (start),
			.inVec  (startVec),
			.myId   (neuronIdT'(g)),
			.req    (req[g]),
			.addr   (reqAddr[g]),
			.gnt    (gnt[g]),
			.rdVld  (rdVld[g]),
			.rdData (rdData),
			.done   (done[g]),
			.result (result[g])
		);
	end

	weightArbiter arbiter (
		.clk     (clk),
		.rstN    (rstN),
		.req     (req),
		.reqAddr (reqAddr),
		.gnt     (gnt),
		.rdVld   (rdVld),
		.rdData  (rdData)
	);

endmodule

// File: tb/denseLayerTb.sv
`timescale 1ns/10ps
`include "layer_cfg.svh"

module denseLayerTb import layerPkg::*;
();

	localparam int TableSize = 7;
	localparam int HoldCount = `OUT_CREDITS + 1 + `IN_DEPTH;
	localparam int RandomCount = 50;
	localparam int TotalVectors = TableSize + HoldCount + RandomCount;
	localparam int TimeoutCycles = TotalVectors * 200 + 1000;
	localparam int HoldCycles = 400;

	logic   clk;
	logic   rstN;
	logic   inVld;
	actVecT inVec;
	logic   inCredit;
	logic   outVld;
	resVecT outVec;
	logic   outCreditRet;

	string  tblName [TableSize];
	actVecT tblVec [TableSize];
	resVecT tblExp [TableSize];
	string  expName [TotalVectors];
	resVecT expVec [TotalVectors];

	int sentCount = 0;
	int rdIdx = 0;
	int creditPulses = 0;
	int arrivals = 0;
	int returnedCount = 0;
	int creditsBack = 0;
	int valueErrors = 0;
	int flowErrors = 0;
	int endErrors = 0;
	int holdCredits = 0;
	int maxGap = 0;
	int cycleCount;
	int gapLeft;

	denseLayer UUT (
		.clk          (clk),
		.rstN         (rstN),
		.inVld        (inVld),
		.inVec        (inVec),
		.inCredit     (inCredit),
		.outVld       (outVld),
		.outVec       (outVec),
		.outCreditRet (outCreditRet)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ##############################
	// Reference model
	// ##############################

	function automatic resVecT modelLayer(input actVecT v);
		resVecT r;
		longint sum;
		longint w;
		longint q;
		for (int n = 0; n < `LAYER_NEURONS; n++)
		begin
			// Bias sits at the product scale.
			sum = longint'((n - 1) * 1024) * 4096;
			for (int i = 0; i < `LAYER_INPUTS; i++)
			begin
				w = longint'((((7 * n + 3 * i + 1) % 11) - 5) * 256);
				sum = sum + w * longint'($signed(v[i]));
			end
			q = sum >>> `FRAC_BITS;
			if (q > 32767)
				q = 32767;
			if (q < 0)
				q = 0;
			r[n] = actT'(q);
		end
		return r;
	endfunction

	function automatic actVecT splat(input actT a);
		actVecT v;
		for (int i = 0; i < `LAYER_INPUTS; i++)
			v[i] = a;
		return v;
	endfunction

	function automatic actVecT randVec();
		actVecT v;
		for (int i = 0; i < `LAYER_INPUTS; i++)
			v[i] = actT'($urandom);
		return v;
	endfunction

	// Results are lanes 3 down to 0.
	task automatic loadTable();
		tblName[0] = "zeroVec";
		tblVec[0] = '0;
		tblExp[0] = {16'h0800, 16'h0400, 16'h0000, 16'h0000};
		tblName[1] = "unitFirst";
		tblVec[1] = '0;
		tblVec[1][0] = 16'h1000;
		tblExp[1] = {16'h0300, 16'h0300, 16'h0300, 16'h0000};
		tblName[2] = "halfStep";
		tblVec[2] = '0;
		tblVec[2][3] = 16'h0800;
		tblExp[2] = {16'h0A00, 16'h0280, 16'h0080, 16'h0000};
		// Floor of a tiny negative product.
		tblName[3] = "tinyAct";
		tblVec[3] = '0;
		tblVec[3][1] = 16'h0001;
		tblExp[3] = {16'h07FF, 16'h0400, 16'h0000, 16'h0000};
		tblName[4] = "rectAllOnes";
		tblVec[4] = splat(16'h1000);
		tblExp[4] = {16'h0600, 16'h0700, 16'h0000, 16'h0000};
		tblName[5] = "allMax";
		tblVec[5] = splat(16'h7FFF);
		tblExp[5] = {16'h0000, 16'h1BFF, 16'h0000, 16'h0BFF};
		// Signs follow neuron 0, so lanes 0 and 3 clip high.
		tblName[6] = "satMix";
		tblVec[6] = {16'h4000, 16'h4000, 16'hC000, 16'hC000, 16'h4000,
			16'h4000, 16'hC000, 16'hC000, 16'h4000, 16'h0000,
			16'hC000, 16'h4000, 16'h4000, 16'hC000, 16'hC000};
		tblExp[6] = {16'h7FFF, 16'h0000, 16'h0000, 16'h7FFF};
	endtask

	// ##############################
	// Producer
	// ##############################

	// Called 1 ns after a rising edge.
	task automatic sendVector(input actVecT v, input resVecT exp, input string name);
		while (`IN_DEPTH + creditPulses - sentCount <= 0)
		begin
			inVld = 1'b0;
			@(posedge clk);
			#1;
		end
		inVld = 1'b1;
		inVec = v;
		expVec[sentCount] = exp;
		expName[sentCount] = name;
		sentCount++;
		@(posedge clk);
		#1;
		inVld = 1'b0;
	endtask

	task automatic waitDrained();
		while (rdIdx != sentCount || returnedCount != arrivals)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// ##############################
	// Consumer
	// ##############################

	always @(negedge clk)
	begin
		if (rstN)
		begin
			if (inCredit)
				creditPulses++;
			if (creditPulses > sentCount)
			begin
				$display("Input credit returned with no vector outstanding");
				flowErrors++;
			end
			if (outVld)
			begin
				if (arrivals - creditsBack >= `OUT_CREDITS)
				begin
					$display("Output vector arrived while the layer held no credit");
					flowErrors++;
				end
				arrivals++;
				if (rdIdx >= sentCount)
				begin
					$display("Output vector arrived with no input outstanding");
					flowErrors++;
				end
				else
				begin
					for (int k = 0; k < `LAYER_NEURONS; k++)
					begin
						if (outVec[k] !== expVec[rdIdx][k])
						begin
							$display("ERROR %s lane %0d: expected %h actual %h",
								expName[rdIdx], k, expVec[rdIdx][k], outVec[k]);
							valueErrors++;
						end
					end
					rdIdx++;
				end
			end
			// The layer counts a returned credit from the next edge on.
			if (outCreditRet)
				creditsBack++;
		end
	end

	// Returns one credit per received vector, with optional gaps.
	initial
	begin
		outCreditRet = 1'b0;
		gapLeft = 0;
		forever
		begin
			@(posedge clk);
			#1;
			outCreditRet = 1'b0;
			if (gapLeft > 0)
				gapLeft--;
			else if (arrivals - returnedCount > 0 && holdCredits == 0)
			begin
				outCreditRet = 1'b1;
				returnedCount++;
				gapLeft = (maxGap == 0) ? 0 : int'($urandom % (maxGap + 1));
			end
		end
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < TimeoutCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
		$display("TESTS FAILED");
		$finish;
	end

	// ##############################
	// Main sequence
	// ##############################

	initial
	begin
		actVecT v;
		int holdBase;
		int seedInit;
		seedInit = $urandom(97791);
		rstN = 1'b0;
		inVld = 1'b0;
		inVec = '0;
		loadTable();
		repeat (3) @(posedge clk);
		#1;
		rstN = 1'b1;
		@(posedge clk);
		#1;

		for (int k = 0; k < TableSize; k++)
			sendVector(tblVec[k], tblExp[k], tblName[k]);
		waitDrained();

		// Withhold output credits.
		holdCredits = 1;
		holdBase = arrivals;
		for (int k = 0; k < HoldCount; k++)
		begin
			v = randVec();
			sendVector(v, modelLayer(v), $sformatf("hold%0d", k));
		end
		repeat (HoldCycles) @(posedge clk);
		#1;
		if (arrivals - holdBase != `OUT_CREDITS)
		begin
			$display("Expected %0d vectors under back-pressure but saw %0d",
				`OUT_CREDITS, arrivals - holdBase);
			endErrors++;
		end
		// Queue full, producer out of credits.
		if (`IN_DEPTH + creditPulses - sentCount != 0)
		begin
			$display("Producer still holds %0d input credits under back-pressure",
				`IN_DEPTH + creditPulses - sentCount);
			endErrors++;
		end
		holdCredits = 0;
		waitDrained();

		maxGap = 3;
		for (int k = 0; k < RandomCount; k++)
		begin
			v = randVec();
			sendVector(v, modelLayer(v), $sformatf("random%0d", k));
		end
		waitDrained();

		if (creditPulses != sentCount)
		begin
			$display("Input credits returned (%0d) do not match vectors sent (%0d)",
				creditPulses, sentCount);
			endErrors++;
		end
		$display("Vectors checked %0d, value errors %0d, flow errors %0d, end errors %0d",
			rdIdx, valueErrors, flowErrors, endErrors);
		if (valueErrors + flowErrors + endErrors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: files.f
+incdir+hw
hw/layerPkg.sv
hw/weightRom.sv
hw/weightArbiter.sv
hw/neuronMac.sv
hw/inputQueue.sv
hw/layerControl.sv
hw/denseLayer.sv
tb/denseLayerTb.sv

// File: run.sh
#!/bin/sh
# Build and run the dense layer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module denseLayerTb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/VdenseLayerTb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q '^TESTS PASSED$'; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
